// ==== key_pkg.sv ====
// Keyboard side definitions for the player-control front end.
// Scan codes are PS/2 set 2 make codes without the E0 prefix, so the
// arrow keys and their keypad twins share one code each.
// Alt and ctrl are not decoded and fall into OP_NONE.
`default_nettype none

package key_pkg;

	// ==============================
	// Scan codes
	// ==============================
	localparam logic [7:0] SC_UP     = 8'h75;
	localparam logic [7:0] SC_DOWN   = 8'h72;
	localparam logic [7:0] SC_LEFT   = 8'h6B;
	localparam logic [7:0] SC_RIGHT  = 8'h74;
	localparam logic [7:0] SC_COIN   = 8'h76; // Escape
	localparam logic [7:0] SC_START1 = 8'h05; // F1
	localparam logic [7:0] SC_START2 = 8'h06; // F2
	localparam logic [7:0] SC_FIRE   = 8'h29; // Space

	// Button addressed by one key event
	typedef enum logic [3:0] {
		OP_UP,
		OP_DOWN,
		OP_LEFT,
		OP_RIGHT,
		OP_FIRE,
		OP_COIN,
		OP_START1,
		OP_START2,
		OP_NONE
	} key_op_t;

	// Four-phase req/ack receiver
	typedef enum logic {
		KS_IDLE,
		KS_ACK
	} key_state_t;

endpackage

`default_nettype wire

// ==== ctrl_pkg.sv ====
// Player and port-byte layout shared by the filters and the mapper.
// Port bits not listed here are unused and read as 1 on the bus.
`default_nettype none

package ctrl_pkg;

	localparam int NUM_PLAYERS = 2;
	localparam int PORT_W      = 8;

	// Joystick vector layout per player
	localparam int JOY_W     = 5;
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;

	// Cycles a synchronized vector must hold before it is taken
	localparam int DEBOUNCE_CYCLES = 16;
	localparam int DEBOUNCE_W      = $clog2(DEBOUNCE_CYCLES + 1);

	// ==============================
	// Port byte bit positions
	// ==============================
	localparam int IN0_UP     = 0;
	localparam int IN0_LEFT   = 1;
	localparam int IN0_RIGHT  = 2;
	localparam int IN0_DOWN   = 3;
	localparam int IN0_COIN   = 5;
	localparam int IN1_FIRE   = 4;
	localparam int IN1_START1 = 5;
	localparam int IN1_START2 = 6;

endpackage

`default_nettype wire

// ==== pad_if.sv ====
// One set of pad controls, active high.
// Used by the keyboard decoder and each joystick filter.
`default_nettype none

interface pad_if;

	logic up;
	logic down;
	logic left;
	logic right;
	logic fire;

	modport src  (output up, down, left, right, fire);
	modport sink (input  up, down, left, right, fire);

endinterface

`default_nettype wire

// ==== key_decoder.sv ====
// Keyboard event receiver on a four-phase req/ack handshake.
// Host must hold key_code and key_pressed stable while key_req is high
// and may raise key_req again only once key_ack is low.
// Unknown scan codes are acknowledged and leave all buttons unchanged.
`default_nettype none

module key_decoder (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       key_req,
	input  logic [7:0] key_code,
	input  logic       key_pressed,
	output logic       key_ack,
	output logic       coin,
	output logic       start1,
	output logic       start2,
	pad_if.src         pad
);

	key_pkg::key_op_t    key_op;
	key_pkg::key_state_t state;

	logic btn_up;
	logic btn_down;
	logic btn_left;
	logic btn_right;
	logic btn_fire;
	logic btn_coin;
	logic btn_start1;
	logic btn_start2;

	// Scan code to button
	always_comb begin
		case (key_code)
			key_pkg::SC_UP:     key_op = key_pkg::OP_UP;
			key_pkg::SC_DOWN:   key_op = key_pkg::OP_DOWN;
			key_pkg::SC_LEFT:   key_op = key_pkg::OP_LEFT;
			key_pkg::SC_RIGHT:  key_op = key_pkg::OP_RIGHT;
			key_pkg::SC_FIRE:   key_op = key_pkg::OP_FIRE;
			key_pkg::SC_COIN:   key_op = key_pkg::OP_COIN;
			key_pkg::SC_START1: key_op = key_pkg::OP_START1;
			key_pkg::SC_START2: key_op = key_pkg::OP_START2;
			default:            key_op = key_pkg::OP_NONE;
		endcase
	end

	// ==============================
	// Handshake FSM and button state
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= key_pkg::KS_IDLE;
			btn_up     <= 1'b0;
			btn_down   <= 1'b0;
			btn_left   <= 1'b0;
			btn_right  <= 1'b0;
			btn_fire   <= 1'b0;
			btn_coin   <= 1'b0;
			btn_start1 <= 1'b0;
			btn_start2 <= 1'b0;
		end else begin
			case (state)
				key_pkg::KS_IDLE: if (key_req) begin
					state <= key_pkg::KS_ACK; // Event taken on this edge
					case (key_op)
						key_pkg::OP_UP:     btn_up     <= key_pressed;
						key_pkg::OP_DOWN:   btn_down   <= key_pressed;
						key_pkg::OP_LEFT:   btn_left   <= key_pressed;
						key_pkg::OP_RIGHT:  btn_right  <= key_pressed;
						key_pkg::OP_FIRE:   btn_fire   <= key_pressed;
						key_pkg::OP_COIN:   btn_coin   <= key_pressed;
						key_pkg::OP_START1: btn_start1 <= key_pressed;
						key_pkg::OP_START2: btn_start2 <= key_pressed;
						default: ;                      // OP_NONE, ack only
					endcase
				end
				key_pkg::KS_ACK: if (!key_req) begin
					state <= key_pkg::KS_IDLE;
				end
				default: state <= key_pkg::KS_IDLE;
			endcase
		end
	end

	// State is a single flop, so ack comes straight from a register
	assign key_ack = (state == key_pkg::KS_ACK);

	assign pad.up    = btn_up;
	assign pad.down  = btn_down;
	assign pad.left  = btn_left;
	assign pad.right = btn_right;
	assign pad.fire  = btn_fire;
	assign coin      = btn_coin;
	assign start1    = btn_start1;
	assign start2    = btn_start2;

endmodule

`default_nettype wire

// ==== joystick_filter.sv ====
// Synchronizer and debouncer for one player's joystick lines.
// Output follows the raw vector two sync cycles plus DEBOUNCE_CYCLES
// after its last change; shorter pulses are dropped entirely.
// No strobe marks an update.
`default_nettype none

module joystick_filter (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic [ctrl_pkg::JOY_W-1:0] joy_raw,
	pad_if.src                         pad
);

	logic [ctrl_pkg::JOY_W-1:0]      sync_a;
	logic [ctrl_pkg::JOY_W-1:0]      sync_b;
	logic [ctrl_pkg::JOY_W-1:0]      stable;   // Previous synchronized vector
	logic [ctrl_pkg::JOY_W-1:0]      held;
	logic [ctrl_pkg::DEBOUNCE_W-1:0] count;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sync_a <= '0;
			sync_b <= '0;
			stable <= '0;
			held   <= '0;
			count  <= '0;
		end else begin
			sync_a <= joy_raw;
			sync_b <= sync_a;
			stable <= sync_b;

			// Any change restarts the wait
			if (sync_b != stable) begin
				count <= '0;
			end else if (count != ctrl_pkg::DEBOUNCE_W'(ctrl_pkg::DEBOUNCE_CYCLES)) begin
				count <= count + 1'b1;
			end else begin
				held <= stable;                    // Saturated, vector accepted
			end
		end
	end

	assign pad.up    = held[ctrl_pkg::JOY_UP];
	assign pad.down  = held[ctrl_pkg::JOY_DOWN];
	assign pad.left  = held[ctrl_pkg::JOY_LEFT];
	assign pad.right = held[ctrl_pkg::JOY_RIGHT];
	assign pad.fire  = held[ctrl_pkg::JOY_FIRE];

endmodule

`default_nettype wire

// ==== control_mapper.sv ====
// Merges keyboard and joystick pads into the two game input bytes.
// Bytes are active low and registered; FFh out of reset.
// Rotation remaps directions only, fire and the coin/start keys pass as is.
`default_nettype none

module control_mapper (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        rotate,
	input  logic                        coin,
	input  logic                        start1,
	input  logic                        start2,
	pad_if.sink                         key_pad,
	pad_if.sink                         joy_pad [ctrl_pkg::NUM_PLAYERS],
	output logic [ctrl_pkg::PORT_W-1:0] in0,
	output logic [ctrl_pkg::PORT_W-1:0] in1
);

	logic [ctrl_pkg::NUM_PLAYERS-1:0] joy_up;
	logic [ctrl_pkg::NUM_PLAYERS-1:0] joy_down;
	logic [ctrl_pkg::NUM_PLAYERS-1:0] joy_left;
	logic [ctrl_pkg::NUM_PLAYERS-1:0] joy_right;
	logic [ctrl_pkg::NUM_PLAYERS-1:0] joy_fire;

	logic any_up, any_down, any_left, any_right, any_fire;
	logic m_up, m_down, m_left, m_right;
	logic [ctrl_pkg::PORT_W-1:0] in0_next;
	logic [ctrl_pkg::PORT_W-1:0] in1_next;

	// Interface array needs constant indices
	for (genvar i = 0; i < ctrl_pkg::NUM_PLAYERS; i++) begin : g_gather
		assign joy_up[i]    = joy_pad[i].up;
		assign joy_down[i]  = joy_pad[i].down;
		assign joy_left[i]  = joy_pad[i].left;
		assign joy_right[i] = joy_pad[i].right;
		assign joy_fire[i]  = joy_pad[i].fire;
	end

	assign any_up    = key_pad.up    | (|joy_up);
	assign any_down  = key_pad.down  | (|joy_down);
	assign any_left  = key_pad.left  | (|joy_left);
	assign any_right = key_pad.right | (|joy_right);
	assign any_fire  = key_pad.fire  | (|joy_fire);

	// Cabinet turned on its side
	assign m_up    = rotate ? any_left  : any_up;
	assign m_down  = rotate ? any_right : any_down;
	assign m_left  = rotate ? any_down  : any_left;
	assign m_right = rotate ? any_up    : any_right;

	// ==============================
	// Byte packing
	// ==============================
	always_comb begin
		in0_next = '0;
		in1_next = '0;
		in0_next[ctrl_pkg::IN0_UP]     = m_up;
		in0_next[ctrl_pkg::IN0_LEFT]   = m_left;
		in0_next[ctrl_pkg::IN0_RIGHT]  = m_right;
		in0_next[ctrl_pkg::IN0_DOWN]   = m_down;
		in0_next[ctrl_pkg::IN0_COIN]   = coin;
		in1_next[ctrl_pkg::IN1_FIRE]   = any_fire;
		in1_next[ctrl_pkg::IN1_START1] = start1;
		in1_next[ctrl_pkg::IN1_START2] = start2;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			in0 <= '1;
			in1 <= '1;
		end else begin
			in0 <= ~in0_next; // Game reads active low
			in1 <= ~in1_next;
		end
	end

endmodule

`default_nettype wire

// ==== arcade_controls.sv ====
// Player-control front end of the arcade core.
// Key events arrive on a req/ack handshake, joysticks as raw async lines.
// in0/in1 are the active-low input ports read by the game CPU.
`default_nettype none

module arcade_controls (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        key_req,
	input  logic [7:0]                  key_code,
	input  logic                        key_pressed,
	input  logic                        rotate,
	input  logic [ctrl_pkg::NUM_PLAYERS-1:0][ctrl_pkg::JOY_W-1:0] joystick,
	output logic                        key_ack,
	output logic [ctrl_pkg::PORT_W-1:0] in0,
	output logic [ctrl_pkg::PORT_W-1:0] in1
);

	logic coin;
	logic start1;
	logic start2;

	pad_if key_pad ();
	pad_if joy_pad [ctrl_pkg::NUM_PLAYERS] ();

	key_decoder key_decoder_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.key_req     (key_req),
		.key_code    (key_code),
		.key_pressed (key_pressed),
		.key_ack     (key_ack),
		.coin        (coin),
		.start1      (start1),
		.start2      (start2),
		.pad         (key_pad)
	);

	// One filter per player
	for (genvar i = 0; i < ctrl_pkg::NUM_PLAYERS; i++) begin : g_joy
		joystick_filter joystick_filter_inst (
			.clk_sys (clk_sys),
			.reset   (reset),
			.joy_raw (joystick[i]),
			.pad     (joy_pad[i])
		);
	end

	control_mapper control_mapper_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.rotate  (rotate),
		.coin    (coin),
		.start1  (start1),
		.start2  (start2),
		.key_pad (key_pad),
		.joy_pad (joy_pad),
		.in0     (in0),
		.in1     (in1)
	);

endmodule

`default_nettype wire

// ==== arcade_controls_checker.sv ====
// Handshake and reset-state assertions for arcade_controls.
// Bound into the RTL top level by the testbench.
`default_nettype none

module arcade_controls_checker (
	input logic       clk_sys,
	input logic       reset,
	input logic       key_req,
	input logic       key_ack,
	input logic [7:0] in0,
	input logic [7:0] in1
);

	// Ack only answers a request
	property ack_rise_on_req;
		@(posedge clk_sys) disable iff (reset) $rose(key_ack) |-> $past(key_req);
	endproperty

	// Ack drops only once the host has let go
	property ack_fall_after_req_low;
		@(posedge clk_sys) disable iff (reset) $fell(key_ack) |-> !$past(key_req);
	endproperty

	property reset_state;
		@(posedge clk_sys) $fell(reset) |-> (in0 == 8'hFF && in1 == 8'hFF && !key_ack);
	endproperty

	ack_rise_check: assert property (ack_rise_on_req)
		else $error("key_ack rose while key_req was low");
	ack_fall_check: assert property (ack_fall_after_req_low)
		else $error("key_ack fell before key_req went low");
	reset_check: assert property (reset_state)
		else $error("ports not idle in the first cycle after reset");

endmodule

`default_nettype wire

// ==== tb_arcade_controls.sv ====
// Directed testbench for arcade_controls.
// Inputs change on rising edges, outputs are sampled on falling edges.
// Joystick checks wait 40 cycles, enough for sync plus debounce.
`default_nettype none

module tb_arcade_controls;

	localparam int CLK_PERIOD = 100;
	localparam int SEND_CYCLES = 24; // One handshake, timeouts included
	localparam int RESET_CYCLES = 10;
	localparam int KEY_CYCLES = 19 * SEND_CYCLES;
	localparam int JOY_CYCLES = 800;
	localparam int ROT_CYCLES = 4 * (2 * SEND_CYCLES + 6);
	localparam int MERGE_CYCLES = 4 * SEND_CYCLES + 3 * 41;
	localparam int ALL_CYCLES = RESET_CYCLES + KEY_CYCLES + JOY_CYCLES + ROT_CYCLES
		+ MERGE_CYCLES;

	// Up, down, left, right, coin, start1, start2, fire
	localparam logic [7:0] KEY_CODES [8] = '{8'h75, 8'h72, 8'h6B, 8'h74,
		8'h76, 8'h05, 8'h06, 8'h29};

	logic clk_sys;
	logic reset;
	logic key_req;
	logic [7:0] key_code;
	logic key_pressed;
	logic rotate;
	logic [ctrl_pkg::NUM_PLAYERS-1:0][4:0] joystick;
	logic key_ack;
	logic [7:0] in0;
	logic [7:0] in1;

	int errors;
	logic [31:0] lfsr;

	// Tracked state for the reference model
	logic k_up, k_down, k_left, k_right, k_fire, k_coin, k_start1, k_start2;
	logic rot_m;
	logic [4:0] joy_m [ctrl_pkg::NUM_PLAYERS];

	arcade_controls arcade_controls_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.key_req     (key_req),
		.key_code    (key_code),
		.key_pressed (key_pressed),
		.rotate      (rotate),
		.joystick    (joystick),
		.key_ack     (key_ack),
		.in0         (in0),
		.in1         (in1)
	);

	bind arcade_controls arcade_controls_checker arcade_controls_checker_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.key_req (key_req),
		.key_ack (key_ack),
		.in0     (in0),
		.in1     (in1)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(ALL_CYCLES * 2 * CLK_PERIOD);
		$display("watchdog expired, tests did not finish in %0d cycles", ALL_CYCLES * 2);
		$display("test failed");
		$finish;
	end

	// ==============================
	// Stimulus and model helpers
	// ==============================
	function automatic logic [4:0] random_vector();
		logic [4:0] v;
		for (int i = 0; i < 5; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]}; // Taps 32 22 2 1
			v[i] = lfsr[0];
		end
		return v;
	endfunction

	function automatic logic [7:0] expected_in0();
		logic up, down, left, right;
		logic [7:0] b;
		up    = k_up    | joy_m[0][3] | joy_m[1][3];
		down  = k_down  | joy_m[0][2] | joy_m[1][2];
		left  = k_left  | joy_m[0][1] | joy_m[1][1];
		right = k_right | joy_m[0][0] | joy_m[1][0];
		b = 8'h00;
		b[0] = rot_m ? left  : up;
		b[1] = rot_m ? down  : left;
		b[2] = rot_m ? up    : right;
		b[3] = rot_m ? right : down;
		b[5] = k_coin;
		return ~b;
	endfunction

	function automatic logic [7:0] expected_in1();
		logic [7:0] b;
		b = 8'h00;
		b[4] = k_fire | joy_m[0][4] | joy_m[1][4];
		b[5] = k_start1;
		b[6] = k_start2;
		return ~b;
	endfunction

	task automatic update_key_model(input logic [7:0] code, input logic pressed);
		case (code)
			8'h75: k_up = pressed;
			8'h72: k_down = pressed;
			8'h6B: k_left = pressed;
			8'h74: k_right = pressed;
			8'h76: k_coin = pressed;
			8'h05: k_start1 = pressed;
			8'h06: k_start2 = pressed;
			8'h29: k_fire = pressed;
			default: ; // Unknown key, no effect
		endcase
	endtask

	task automatic check_ports(input string name);
		assert (in0 == expected_in0()) else begin
			errors++;
			$display("mismatch %s in0 expected %h actual %h", name, expected_in0(), in0);
		end
		assert (in1 == expected_in1()) else begin
			errors++;
			$display("mismatch %s in1 expected %h actual %h", name, expected_in1(), in1);
		end
	endtask

	// Full four-phase handshake for one key event
	task automatic send_key(input logic [7:0] code, input logic pressed);
		int waited;
		@(posedge clk_sys);
		key_code    <= code;
		key_pressed <= pressed;
		key_req     <= 1'b1;
		waited = 0;
		do begin
			@(negedge clk_sys);
			waited++;
		end while (!key_ack && waited < 10);
		assert (key_ack) else begin
			errors++;
			$display("key_ack did not arrive within 10 cycles for code %h", code);
		end
		@(posedge clk_sys);
		key_req <= 1'b0;
		waited = 0;
		do begin
			@(negedge clk_sys);
			waited++;
		end while (key_ack && waited < 10);
		assert (!key_ack) else begin
			errors++;
			$display("key_ack stayed high after key_req dropped for code %h", code);
		end
		update_key_model(code, pressed);
	endtask

	task automatic set_joystick(input int p, input logic [4:0] vec);
		@(posedge clk_sys);
		joystick[p] <= vec;
		joy_m[p] = vec;
		repeat (40) @(negedge clk_sys);
	endtask

	// ==============================
	// Directed tests
	// ==============================
	task automatic test_reset();
		@(negedge clk_sys);
		assert (!key_ack) else begin
			errors++;
			$display("key_ack is high right after reset");
		end
		check_ports("reset");
	endtask

	task automatic test_key_mapping();
		foreach (KEY_CODES[i]) begin
			send_key(KEY_CODES[i], 1'b1);
			check_ports($sformatf("key %h press", KEY_CODES[i]));
			send_key(KEY_CODES[i], 1'b0);
			check_ports($sformatf("key %h release", KEY_CODES[i]));
		end
		send_key(8'h75, 1'b1);
		send_key(8'h11, 1'b1); // Unknown code must not disturb up
		check_ports("unknown key");
		send_key(8'h75, 1'b0);
		check_ports("unknown key cleanup");
	endtask

	task automatic test_joystick();
		for (int p = 0; p < ctrl_pkg::NUM_PLAYERS; p++) begin
			for (int n = 0; n < 8; n++) begin
				set_joystick(p, random_vector());
				check_ports($sformatf("joystick p%0d vector %0d", p, n));
			end
		end
		@(posedge clk_sys);
		joystick[0] <= joy_m[0] ^ 5'b10001; // Short glitch on fire and right
		repeat (3) begin
			@(negedge clk_sys);
			check_ports("glitch");
		end
		@(posedge clk_sys);
		joystick[0] <= joy_m[0];
		repeat (40) begin
			@(negedge clk_sys);
			check_ports("glitch");
		end
		set_joystick(0, 5'b00000);
		set_joystick(1, 5'b00000);
		check_ports("joystick clear");
	endtask

	task automatic test_rotation(input logic [7:0] code, input string dir);
		send_key(code, 1'b1);
		check_ports({"rotate off ", dir});
		@(posedge clk_sys);
		rotate <= 1'b1;
		rot_m = 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_ports({"rotate on ", dir});
		@(posedge clk_sys);
		rotate <= 1'b0;
		rot_m = 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_ports({"rotate back ", dir});
		send_key(code, 1'b0);
	endtask

	task automatic test_merging();
		set_joystick(0, 5'b10000);
		send_key(8'h29, 1'b1);
		check_ports("fire both");
		send_key(8'h29, 1'b0);
		check_ports("fire joystick only");
		send_key(8'h29, 1'b1);
		set_joystick(0, 5'b00000);
		check_ports("fire keyboard only");
		send_key(8'h29, 1'b0);
		check_ports("fire none");
	endtask

	initial begin
		errors      = 0;
		lfsr        = 32'hbede;
		reset       = 1'b1;
		key_req     = 1'b0;
		key_code    = 8'h00;
		key_pressed = 1'b0;
		rotate      = 1'b0;
		joystick    = '0;
		{k_up, k_down, k_left, k_right, k_fire, k_coin, k_start1, k_start2} = 8'h00;
		rot_m       = 1'b0;
		joy_m[0]    = 5'b00000;
		joy_m[1]    = 5'b00000;
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;

		test_reset();
		test_key_mapping();
		test_joystick();
		test_rotation(8'h75, "up");
		test_rotation(8'h72, "down");
		test_rotation(8'h6B, "left");
		test_rotation(8'h74, "right");
		test_merging();

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
key_pkg.sv
ctrl_pkg.sv
pad_if.sv
key_decoder.sv
joystick_filter.sv
control_mapper.sv
arcade_controls.sv
arcade_controls_checker.sv
tb_arcade_controls.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the arcade_controls testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_arcade_controls -o sim_arcade
./obj_dir/sim_arcade | tee sim.log

if grep -qx "test passed" sim.log; then
	exit 0
else
	echo "simulation reported failure, see sim.log"
	exit 1
fi
